// ==== sources.f ====
+incdir+rtl
rtl/rv32_pkg.sv
rtl/control_unit.sv
rtl/core_fsm.sv
rtl/shift_counter.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/pc_unit.sv
rtl/rv32_core.sv
dv/rv32_core_props.sv
dv/rv32_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := rv32_core_tb
FILELIST  := sources.f
VFLAGS    := --binary --timing --assert -j 0
OBJDIR    := obj_dir

SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

// ==== dv/rv32_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_consts.svh"

module rv32_core_tb import rv32_pkg::*; ();

  localparam int          CLK_PERIOD       = 4;
  localparam int          RESET_CYCLES     = 8;
  localparam int          MEM_WORDS        = 256;
  localparam int          LAST             = MEM_WORDS - 1;
  localparam int          NUM_RUNS         = 2;
  localparam int          MAX_INSTRS       = 300;
  localparam int          CYCLES_PER_INSTR = 40;
  localparam int          WATCHDOG_NS      = NUM_RUNS * CLK_PERIOD *
                                             (MAX_INSTRS * CYCLES_PER_INSTR + RESET_CYCLES + 8);
  localparam logic [31:0] SEED             = 32'h9c414a7c;
  localparam logic [31:0] ILLEGAL_WORD     = 32'h0000_0073;

  logic                clk_i;
  logic                rst_n_i;
  logic [`RV_XLEN-1:0] imem_addr_o;
  logic [`RV_XLEN-1:0] imem_data_i;
  logic [`RV_XLEN-1:0] dmem_addr_o;
  logic [`RV_XLEN-1:0] dmem_wdata_o;
  logic                dmem_we_o;
  logic                dmem_re_o;
  logic [`RV_XLEN-1:0] dmem_rdata_i;
  logic                retire_valid_o;
  retire_t             retire_o;
  logic                halt_o;
  logic                illegal_o;

  logic [`RV_XLEN-1:0] imem [MEM_WORDS];
  logic [`RV_XLEN-1:0] dmem [MEM_WORDS];

  // Reference ISA model state
  logic [`RV_XLEN-1:0] model_regs [`RV_NREGS];
  logic [`RV_XLEN-1:0] model_dmem [MEM_WORDS];
  logic [`RV_XLEN-1:0] model_pc;

  logic [31:0]         rng_state = SEED;
  logic [31:0]         cur_ins;
  logic [31:0]         exp_pc;
  logic [31:0]         exp_data;
  logic [4:0]          exp_rd;
  logic                exp_we;
  logic                load_strobed = 1'b0;
  logic                assert_failed;

  rv32_core u_rv32_core (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .imem_addr_o    (imem_addr_o),
    .imem_data_i    (imem_data_i),
    .dmem_addr_o    (dmem_addr_o),
    .dmem_wdata_o   (dmem_wdata_o),
    .dmem_we_o      (dmem_we_o),
    .dmem_re_o      (dmem_re_o),
    .dmem_rdata_i   (dmem_rdata_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .halt_o         (halt_o),
    .illegal_o      (illegal_o)
  );

  // Both memories answer in the same cycle
  assign imem_data_i  = imem[imem_addr_o[9:2]];
  assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];

  assign assert_failed = u_rv32_core.u_rv32_core_props.prop_failed;

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state ^ (rng_state >> 16);
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0    : return alt ? a - b : a + b;
      3'd1    : return a << b[4:0];
      3'd2    : return {31'd0, $signed(a) < $signed(b)};
      3'd3    : return {31'd0, a < b};
      3'd4    : return a ^ b;
      3'd5    : return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6    : return a | b;
      default : return a & b;
    endcase
  endfunction

  // x31 holds 64 for the whole run and never appears as rd
  function automatic logic [31:0] rand_instr(input int idx);
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] off;
    logic [31:0] tgt;
    logic [31:0] a;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  shamt;
    logic [2:0]  f3;
    logic [2:0]  bf3;
    int          span;
    r     = next_rand();
    r2    = next_rand();
    r3    = next_rand();
    rd    = 5'(r2 % 31);
    rs1   = r2[9:5];
    rs2   = r2[14:10];
    f3    = r2[17:15];
    bf3   = (f3[2:1] == 2'b01) ? {2'b00, f3[0]} : f3;
    span  = (LAST - idx < 16) ? LAST - idx : 16;
    // Forward target that never passes the stop word
    off   = 32'(4 * (1 + int'(r2[27:20]) % span));
    tgt   = 32'(4 * idx) + off - 32'd64 + {31'd0, r[0]};
    a     = {22'd0, r3[7:0], 2'b00} - 32'd64;
    shamt = (r[1:0] == 2'd0) ? 5'd0 : ((r[1:0] == 2'd1) ? 5'd31 : r[6:2]);
    f7    = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[7], 5'd0} : 7'd0;
    case (f3)
      3'd1    : imm = {7'd0, shamt};
      3'd5    : imm = {1'b0, r[7], 5'd0, shamt};
      default : imm = r3[11:0];
    endcase
    case ((r >> 12) % 10)
      0       : return {r3[31:12], rd, r[0] ? 7'h37 : 7'h17};
      1, 2    : return {imm, rs1, f3, rd, 7'h13};
      3, 4    : return {f7, rs2, rs1, f3, rd, 7'h33};
      5       : return {off[12], off[10:5], rs2, rs1, bf3, off[4:1], off[11], 7'h63};
      6       : return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
      7       : return {tgt[11:0], 5'd31, 3'd0, rd, 7'h67};
      8       : return {a[11:0], 5'd31, 3'b010, rd, 7'h03};
      default : return {a[11:5], rs2, 5'd31, 3'b010, a[4:0], 7'h23};
    endcase
  endfunction

  task automatic load_program(input logic [31:0] stop_word);
    imem[0] = {12'd64, 5'd0, 3'b000, 5'd31, 7'h13};
    for (int i = 1; i < LAST; i++) begin
      imem[i] = rand_instr(i);
    end
    imem[LAST] = stop_word;
    for (int i = 0; i < MEM_WORDS; i++) begin
      dmem[i]       = (32'(i) * 32'h9e3779b1) ^ 32'h5bd1e995;
      model_dmem[i] = dmem[i];
    end
    for (int i = 0; i < `RV_NREGS; i++) begin
      model_regs[i] = '0;
    end
    model_pc     = `RV_RESET_PC;
    load_strobed = 1'b0;
  endtask

  task automatic model_step(output logic [31:0] pc, output logic [4:0] rd,
                            output logic [31:0] data, output logic we);
    logic [31:0] ins;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] next_pc;
    logic [31:0] addr;
    logic [2:0]  f3;
    logic        taken;
    logic        wr;
    ins     = imem[model_pc[9:2]];
    f3      = ins[14:12];
    rs1v    = model_regs[ins[19:15]];
    rs2v    = model_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    pc      = model_pc;
    rd      = ins[11:7];
    data    = '0;
    wr      = 1'b0;
    next_pc = model_pc + 32'd4;
    if (ins == `RV_HALT_INSTR) begin
      fail_now("core retired the halt instruction");
    end
    case (ins[6:0])
      7'h37 : begin
        data = {ins[31:12], 12'd0};
        wr   = 1'b1;
      end
      7'h17 : begin
        data = model_pc + {ins[31:12], 12'd0};
        wr   = 1'b1;
      end
      7'h6f : begin
        data    = model_pc + 32'd4;
        wr      = 1'b1;
        next_pc = model_pc + imm_j;
      end
      7'h67 : begin
        data    = model_pc + 32'd4;
        wr      = 1'b1;
        next_pc = (rs1v + imm_i) & ~32'd1;
      end
      7'h63 : begin
        case (f3)
          3'd0    : taken = (rs1v == rs2v);
          3'd1    : taken = (rs1v != rs2v);
          3'd4    : taken = ($signed(rs1v) < $signed(rs2v));
          3'd5    : taken = ($signed(rs1v) >= $signed(rs2v));
          3'd6    : taken = (rs1v < rs2v);
          default : taken = (rs1v >= rs2v);
        endcase
        if (taken) next_pc = model_pc + imm_b;
      end
      7'h03 : begin
        addr = rs1v + imm_i;
        data = model_dmem[addr[9:2]];
        wr   = 1'b1;
      end
      7'h23 : begin
        addr = rs1v + imm_s;
        model_dmem[addr[9:2]] = rs2v;
      end
      7'h13 : begin
        data = alu_ref(f3, ins[30] && f3 == 3'd5, rs1v, imm_i);
        wr   = 1'b1;
      end
      7'h33 : begin
        data = alu_ref(f3, ins[30], rs1v, rs2v);
        wr   = 1'b1;
      end
      default : fail_now("core retired an instruction outside the supported set");
    endcase
    we = wr && (rd != 5'd0);
    if (we) model_regs[rd] = data;
    model_pc = next_pc;
  endtask

  // Memory strobes and retire pulses are sampled on the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i && assert_failed) begin
      fail_now("a bound assertion on the core ports failed");
    end
    cur_ins = imem[model_pc[9:2]];
    if (rst_n_i && dmem_we_o) begin
      check("store opcode", 32'h23, 32'(cur_ins[6:0]));
      check("store address",
            model_regs[cur_ins[19:15]] + {{20{cur_ins[31]}}, cur_ins[31:25], cur_ins[11:7]},
            dmem_addr_o);
      check("store data", model_regs[cur_ins[24:20]], dmem_wdata_o);
      dmem[dmem_addr_o[9:2]] = dmem_wdata_o;
    end
    if (rst_n_i && dmem_re_o) begin
      check("load opcode", 32'h03, 32'(cur_ins[6:0]));
      check("load address",
            model_regs[cur_ins[19:15]] + {{20{cur_ins[31]}}, cur_ins[31:20]},
            dmem_addr_o);
      load_strobed = 1'b1;
    end
    if (rst_n_i && retire_valid_o) begin
      check("load strobe", 32'(cur_ins[6:0] == 7'h03), 32'(load_strobed));
      load_strobed = 1'b0;
      model_step(exp_pc, exp_rd, exp_data, exp_we);
      check("retire pc", exp_pc, retire_o.pc);
      check("retire we", 32'(exp_we), 32'(retire_o.we));
      if (exp_we) begin
        check("retire rd", 32'(exp_rd), 32'(retire_o.rd));
        check("retire data", exp_data, retire_o.data);
      end
    end
  end

  task automatic run_program(input logic [31:0] stop_word);
    load_program(stop_word);
    rst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check("reset pc", `RV_RESET_PC, imem_addr_o);
    check("reset strobes and flags", 32'd0,
          32'({retire_valid_o, dmem_we_o, dmem_re_o, halt_o, illegal_o}));
    while (!(halt_o || illegal_o)) @(negedge clk_i);
    // A few idle cycles so the bound checks see the core stay stopped
    repeat (4) @(negedge clk_i);
    check("stop pc", model_pc, imem_addr_o);
    check("stop word", stop_word, imem[model_pc[9:2]]);
    check("halt flag", 32'(stop_word == `RV_HALT_INSTR), 32'(halt_o));
    check("illegal flag", 32'(stop_word != `RV_HALT_INSTR), 32'(illegal_o));
    for (int i = 0; i < MEM_WORDS; i++) begin
      check($sformatf("dmem word %0d", i), model_dmem[i], dmem[i]);
    end
    if (assert_failed) begin
      fail_now("a bound assertion on the core ports failed");
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_now("core did not halt within the watchdog limit");
  end

  initial begin
    rst_n_i = 1'b0;
    run_program(`RV_HALT_INSTR);
    run_program(ILLEGAL_WORD);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/rv32_core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_core_props import rv32_pkg::*; (
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    retire_valid_o,
  input logic    dmem_we_o,
  input logic    dmem_re_o,
  input logic    halt_o,
  input logic    illegal_o,
  input retire_t retire_o
);

  // Sticky flag raised by any failing property
  logic prop_failed = 1'b0;

  // Strobes belong to EXEC, retire to WB
  a_retire_vs_strobe : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(retire_valid_o && (dmem_we_o || dmem_re_o)))
    else begin
      prop_failed = 1'b1;
      $error("retire pulse overlaps a data memory strobe");
    end

  a_one_strobe : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dmem_we_o && dmem_re_o))
    else begin
      prop_failed = 1'b1;
      $error("read and write strobes high together");
    end

  a_no_retire_stopped : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (halt_o || illegal_o) |-> !retire_valid_o)
    else begin
      prop_failed = 1'b1;
      $error("retire after the core stopped");
    end

  a_no_x0_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (retire_o.rd == 5'd0) |-> !retire_o.we)
    else begin
      prop_failed = 1'b1;
      $error("retire reports a write to x0");
    end

endmodule

bind rv32_core rv32_core_props u_rv32_core_props (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .retire_valid_o (retire_valid_o),
  .dmem_we_o      (dmem_we_o),
  .dmem_re_o      (dmem_re_o),
  .halt_o         (halt_o),
  .illegal_o      (illegal_o),
  .retire_o       (retire_o)
);

`default_nettype wire

// ==== rtl/rv32_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_consts.svh"

module rv32_core import rv32_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  input  logic [`RV_XLEN-1:0] imem_data_i,
  output logic [`RV_XLEN-1:0] dmem_addr_o,
  output logic [`RV_XLEN-1:0] dmem_wdata_o,
  output logic                dmem_we_o,
  output logic                dmem_re_o,
  input  logic [`RV_XLEN-1:0] dmem_rdata_i,
  output logic                retire_valid_o,
  output retire_t             retire_o,
  output logic                halt_o,
  output logic                illegal_o
);

  instr_t                      instr;
  ctrl_t                       ctrl;
  core_state_t                 state;
  logic                        shift_load;
  logic                        shift_done;
  logic [$clog2(`RV_XLEN)-1:0] shift_amount;
  logic                        rf_we;
  logic                        pc_we;
  logic [`RV_XLEN-1:0]         rs1_data;
  logic [`RV_XLEN-1:0]         rs2_data;
  logic [`RV_XLEN-1:0]         alu_result;
  logic [`RV_XLEN-1:0]         pc;
  logic [`RV_XLEN-1:0]         wb_data;

  core_fsm u_core_fsm (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .imem_data_i    (instr_t'(imem_data_i)),
    .ctrl_i         (ctrl),
    .shift_done_i   (shift_done),
    .instr_o        (instr),
    .state_o        (state),
    .shift_load_o   (shift_load),
    .rf_we_o        (rf_we),
    .pc_we_o        (pc_we),
    .dmem_re_o      (dmem_re_o),
    .dmem_we_o      (dmem_we_o),
    .retire_valid_o (retire_valid_o),
    .halt_o         (halt_o),
    .illegal_o      (illegal_o)
  );

  control_unit u_control_unit (
    .instr_i (instr),
    .ctrl_o  (ctrl)
  );

  // Shift amount from the immediate or from rs2, whichever feeds operand B
  assign shift_amount = ctrl.alu_b_sel ? ctrl.imm[$clog2(`RV_XLEN)-1:0]
                                       : rs2_data[$clog2(`RV_XLEN)-1:0];

  shift_counter u_shift_counter (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .load_i   (shift_load),
    .amount_i (shift_amount),
    .done_o   (shift_done)
  );

  alu u_alu (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ctrl_i       (ctrl),
    .state_i      (state),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .pc_i         (pc),
    .shift_done_i (shift_done),
    .result_o     (alu_result)
  );

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .we_i       (rf_we),
    .rs1_i      (ctrl.rs1),
    .rs2_i      (ctrl.rs2),
    .rd_i       (ctrl.rd),
    .wdata_i    (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  pc_unit u_pc_unit (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .we_i         (pc_we),
    .ctrl_i       (ctrl),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .alu_result_i (alu_result),
    .pc_o         (pc)
  );

  // Writeback select; the memory still answers the load address in WB
  always_comb begin
    case (ctrl.w_sel)
      2'd1    : wb_data = dmem_rdata_i;
      2'd2    : wb_data = pc + 'd4;
      2'd3    : wb_data = ctrl.imm;
      default : wb_data = alu_result;
    endcase
  end

  assign imem_addr_o  = pc;
  assign dmem_addr_o  = alu_result;
  assign dmem_wdata_o = rs2_data;

  assign retire_o.pc   = pc;
  assign retire_o.rd   = ctrl.rd;
  assign retire_o.data = wb_data;
  assign retire_o.we   = ctrl.wen && (ctrl.rd != 5'd0);

endmodule

`default_nettype wire

// ==== rtl/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_consts.svh"

module pc_unit import rv32_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                we_i,
  input  ctrl_t               ctrl_i,
  input  logic [`RV_XLEN-1:0] rs1_data_i,
  input  logic [`RV_XLEN-1:0] rs2_data_i,
  input  logic [`RV_XLEN-1:0] alu_result_i,
  output logic [`RV_XLEN-1:0] pc_o
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_next;
  logic                cond;

  always_comb begin
    case (ctrl_i.funct3)
      3'b000  : cond = (rs1_data_i == rs2_data_i);
      3'b001  : cond = (rs1_data_i != rs2_data_i);
      3'b100  : cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
      3'b101  : cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      3'b110  : cond = (rs1_data_i < rs2_data_i);
      3'b111  : cond = (rs1_data_i >= rs2_data_i);
      default : cond = 1'b0;
    endcase
  end

  always_comb begin
    if ((ctrl_i.branch && cond) || ctrl_i.jal) begin
      pc_next = pc_q + ctrl_i.imm;
    end else if (ctrl_i.jalr) begin
      pc_next = {alu_result_i[`RV_XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_q + 'd4;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= `RV_RESET_PC;
    end else if (we_i) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_consts.svh"

module reg_file (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         we_i,
  input  logic [$clog2(`RV_NREGS)-1:0] rs1_i,
  input  logic [$clog2(`RV_NREGS)-1:0] rs2_i,
  input  logic [$clog2(`RV_NREGS)-1:0] rd_i,
  input  logic [`RV_XLEN-1:0]          wdata_i,
  output logic [`RV_XLEN-1:0]          rs1_data_o,
  output logic [`RV_XLEN-1:0]          rs2_data_o
);

  logic [`RV_XLEN-1:0] regs_q [`RV_NREGS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs_q[rd_i] <= wdata_i;
    end
  end

  // x0 is never written, so it reads back zero
  assign rs1_data_o = regs_q[rs1_i];
  assign rs2_data_o = regs_q[rs2_i];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_consts.svh"

module alu import rv32_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  ctrl_t               ctrl_i,
  input  core_state_t         state_i,
  input  logic [`RV_XLEN-1:0] rs1_data_i,
  input  logic [`RV_XLEN-1:0] rs2_data_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  input  logic                shift_done_i,
  output logic [`RV_XLEN-1:0] result_o
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] arith;
  logic [`RV_XLEN-1:0] shift_q;
  logic [`RV_XLEN-1:0] shift_in;
  logic [`RV_XLEN-1:0] shift_step;
  logic                fill;

  assign op_a = ctrl_i.alu_a_sel ? pc_i : rs1_data_i;
  assign op_b = ctrl_i.alu_b_sel ? ctrl_i.imm : rs2_data_i;

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_SUB  : arith = op_a - op_b;
      ALU_AND  : arith = op_a & op_b;
      ALU_OR   : arith = op_a | op_b;
      ALU_XOR  : arith = op_a ^ op_b;
      ALU_SLT  : arith = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU : arith = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      default  : arith = op_a + op_b;
    endcase
  end

  // One bit per step; EXEC already takes the first step
  assign shift_in   = (state_i == EXEC) ? op_a : shift_q;
  assign fill       = (ctrl_i.alu_op == ALU_SRA) & shift_in[`RV_XLEN-1];
  assign shift_step = (ctrl_i.alu_op == ALU_SLL) ? {shift_in[`RV_XLEN-2:0], 1'b0}
                                                 : {fill, shift_in[`RV_XLEN-1:1]};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shift_q <= '0;
    end else if (ctrl_i.is_shift && state_i == EXEC) begin
      shift_q <= shift_done_i ? op_a : shift_step;
    end else if (state_i == SHIFT && !shift_done_i) begin
      shift_q <= shift_step;
    end
  end

  assign result_o = ctrl_i.is_shift ? shift_q : arith;

endmodule

`default_nettype wire

// ==== rtl/shift_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_consts.svh"

module shift_counter (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         load_i,
  input  logic [$clog2(`RV_XLEN)-1:0]  amount_i,
  output logic                         done_o
);

  logic [$clog2(`RV_XLEN)-1:0] count_q;
  logic [$clog2(`RV_XLEN)-1:0] count;

  // The amount counts as live during the load cycle, so zero skips SHIFT
  assign count  = load_i ? amount_i : count_q;
  assign done_o = (count == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      count_q <= done_o ? '0 : count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/core_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_fsm import rv32_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  instr_t      imem_data_i,
  input  ctrl_t       ctrl_i,
  input  logic        shift_done_i,
  output instr_t      instr_o,
  output core_state_t state_o,
  output logic        shift_load_o,
  output logic        rf_we_o,
  output logic        pc_we_o,
  output logic        dmem_re_o,
  output logic        dmem_we_o,
  output logic        retire_valid_o,
  output logic        halt_o,
  output logic        illegal_o
);

  core_state_t state_q;
  core_state_t state_d;
  instr_t      instr_q;
  logic        halt_q;
  logic        illegal_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH : state_d = EXEC;
      EXEC  : begin
        if (ctrl_i.halt || ctrl_i.illegal) begin
          state_d = STOP;
        end else if (ctrl_i.is_shift && !shift_done_i) begin
          state_d = SHIFT;
        end else begin
          state_d = WB;
        end
      end
      SHIFT : if (shift_done_i) state_d = WB;
      WB    : state_d = FETCH;
      default : state_d = STOP;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= FETCH;
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sticky stop cause, halt word wins over illegal
      if (state_q == EXEC) begin
        halt_q    <= halt_q | ctrl_i.halt;
        illegal_q <= illegal_q | (ctrl_i.illegal & ~ctrl_i.halt);
      end
    end
  end

  // Instruction register, captured at the end of FETCH
  always_ff @(posedge clk_i) begin
    if (state_q == FETCH) begin
      instr_q <= imem_data_i;
    end
  end

  assign instr_o = instr_q;
  assign state_o = state_q;

  assign shift_load_o   = (state_q == EXEC) && ctrl_i.is_shift;
  assign dmem_re_o      = (state_q == EXEC) && ctrl_i.dren;
  assign dmem_we_o      = (state_q == EXEC) && ctrl_i.dwen;
  assign rf_we_o        = (state_q == WB) && ctrl_i.wen;
  assign pc_we_o        = (state_q == WB);
  assign retire_valid_o = (state_q == WB);
  assign halt_o         = halt_q;
  assign illegal_o      = illegal_q;

endmodule

`default_nettype wire

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_consts.svh"

module control_unit import rv32_pkg::*; (
  input  instr_t instr_i,
  output ctrl_t  ctrl_o
);

  opcode_t             opcode;
  logic [2:0]          funct3;
  logic                bit30;
  logic                arith_op;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign opcode   = instr_i.r.opcode;
  assign funct3   = instr_i.r.funct3;
  assign bit30    = instr_i.r.funct7[5];
  assign arith_op = (opcode == IMMED) || (opcode == REGREG);

  // Sign-extended immediates, one per format view
  assign imm_i = {{20{instr_i.i.imm11_00[11]}}, instr_i.i.imm11_00};
  assign imm_s = {{20{instr_i.s.imm11_05[6]}}, instr_i.s.imm11_05, instr_i.s.imm04_00};
  assign imm_b = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                  instr_i.b.imm10_05, instr_i.b.imm04_01, 1'b0};
  assign imm_u = {instr_i.u.imm31_12, 12'b0};
  assign imm_j = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                  instr_i.j.imm11, instr_i.j.imm10_01, 1'b0};

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.rs1    = instr_i.r.rs1;
    ctrl_o.rs2    = instr_i.r.rs2;
    ctrl_o.rd     = instr_i.r.rd;
    ctrl_o.funct3 = funct3;

    case (opcode)
      LUI, AUIPC : ctrl_o.imm = imm_u;
      JAL        : ctrl_o.imm = imm_j;
      BRANCH     : ctrl_o.imm = imm_b;
      STORE      : ctrl_o.imm = imm_s;
      default    : ctrl_o.imm = imm_i;
    endcase

    ctrl_o.alu_a_sel = (opcode == AUIPC);
    ctrl_o.alu_b_sel = !((opcode == REGREG) || (opcode == BRANCH));

    // Loads, stores, AUIPC and JALR all resolve to an add
    ctrl_o.alu_op = ALU_ADD;
    if (arith_op) begin
      case (funct3)
        3'b000  : ctrl_o.alu_op = (opcode == REGREG && bit30) ? ALU_SUB : ALU_ADD;
        3'b001  : ctrl_o.alu_op = ALU_SLL;
        3'b010  : ctrl_o.alu_op = ALU_SLT;
        3'b011  : ctrl_o.alu_op = ALU_SLTU;
        3'b100  : ctrl_o.alu_op = ALU_XOR;
        3'b101  : ctrl_o.alu_op = bit30 ? ALU_SRA : ALU_SRL;
        3'b110  : ctrl_o.alu_op = ALU_OR;
        default : ctrl_o.alu_op = ALU_AND;
      endcase
    end
    ctrl_o.is_shift = arith_op && (funct3[1:0] == 2'b01);

    case (opcode)
      LUI, AUIPC, JAL, JALR, LOAD, IMMED, REGREG : ctrl_o.wen = 1'b1;
      default                                    : ctrl_o.wen = 1'b0;
    endcase

    case (opcode)
      LOAD      : ctrl_o.w_sel = 2'd1;
      JAL, JALR : ctrl_o.w_sel = 2'd2;
      LUI       : ctrl_o.w_sel = 2'd3;
      default   : ctrl_o.w_sel = 2'd0;
    endcase

    ctrl_o.dren   = (opcode == LOAD);
    ctrl_o.dwen   = (opcode == STORE);
    ctrl_o.branch = (opcode == BRANCH);
    ctrl_o.jal    = (opcode == JAL);
    ctrl_o.jalr   = (opcode == JALR);

    ctrl_o.halt = (instr_i == `RV_HALT_INSTR);

    // Only funct7 of zero or SUB/SRA are accepted on register ops
    case (opcode)
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, IMMED : ctrl_o.illegal = 1'b0;
      REGREG  : ctrl_o.illegal = (instr_i.r.funct7 != 7'b000_0000) &&
                                 (instr_i.r.funct7 != 7'b010_0000);
      default : ctrl_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv32_pkg.sv ====
`default_nettype none

`include "rv32_consts.svh"

package rv32_pkg;

  // RV32I base opcodes, MISCMEM and SYSTEM decode as illegal
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_type_t;

  // One instruction word, seen through every encoding format
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_t;

  typedef struct packed {
    alu_op_t             alu_op;
    logic                alu_a_sel;  // 0 rs1, 1 PC
    logic                alu_b_sel;  // 0 rs2, 1 immediate
    logic [`RV_XLEN-1:0] imm;
    logic                is_shift;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic                wen;
    logic [1:0]          w_sel;      // 0 ALU, 1 load data, 2 PC+4, 3 immediate
    logic                dren;
    logic                dwen;
    logic                branch;
    logic [2:0]          funct3;
    logic                jal;
    logic                jalr;
    logic                halt;
    logic                illegal;
  } ctrl_t;

  typedef enum logic [2:0] {
    FETCH,
    EXEC,
    SHIFT,
    WB,
    STOP
  } core_state_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] data;
    logic                we;
  } retire_t;

endpackage

`default_nettype wire

// ==== rtl/rv32_consts.svh ====
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

// Data path and address width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NREGS 32

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// jal x0, 0 spins on itself and stops the core
`define RV_HALT_INSTR 32'h0000_006f

`endif
